// File: files.f
common/bp_pkg.sv
hw/branch_history.sv
tage/base_table.sv
tage/tagged_table.sv
tage/predict_select.sv
tage/update_ctrl.sv
hw/bp_top.sv
test/bp_checker.sv
test/tb_bp_top.sv

// File: run.sh
#!/bin/sh
# build the branch predictor testbench with verilator, run it, then grep the log

rm -f sim.log

verilator --binary --timing --assert -f files.f --top-module tb_bp_top -Mdir obj_dir \
	&& ./obj_dir/Vtb_bp_top | tee sim.log

grep -qx ">>> PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: test/tb_bp_top.sv
`timescale 1ns/1ps

module tb_bp_top;

	import bp_pkg::*;

	localparam int BASE_IDX_W = 6;
	localparam int TAG_IDX_W = 5;
	localparam int T1_HIST = 8;
	localparam int T2_HIST = 16;
	localparam int T_DEPTH = 2 ** TAG_IDX_W;
	localparam int RST_CYCLES = 4;
	localparam int N_RAND = 60;
	// idle opcode driven while a branch resolves
	localparam alu_op_t OP_ALU = 6'b000000;

	// one row of stimulus, expected fields filled by the model
	typedef struct packed {
		alu_op_t op;
		pc_t pc;
		pc_t imm;
		logic taken;
		logic exp_taken;
		pc_t exp_next_pc;
	} stim_t;

	logic clk;
	logic rst_n;
	alu_op_t alu_op;
	pc_t pc;
	pc_t imm;
	logic resolve;
	logic taken;
	logic pred_taken;
	pc_t next_pc;

	stim_t tbl[$];
	string names[$];
	int learn_first;
	int cycles;
	int cycle_limit;
	logic [31:0] lcg_state;

	// reference state, t1 at [0] and t2 at [1]
	ctr2_t m_base [2 ** BASE_IDX_W];
	logic m_valid [2][T_DEPTH];
	logic [TAG_W-1:0] m_tag [2][T_DEPTH];
	ctr3_t m_ctr [2][T_DEPTH];
	logic [T2_HIST-1:0] m_hist;

	bp_top #(
		.BASE_IDX_W(BASE_IDX_W),
		.TAG_IDX_W(TAG_IDX_W),
		.T1_HIST(T1_HIST),
		.T2_HIST(T2_HIST)
	) dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.i_alu_op(alu_op),
		.i_pc(pc),
		.i_imm(imm),
		.i_resolve(resolve),
		.i_taken(taken),
		.o_pred_taken(pred_taken),
		.o_next_pc(next_pc)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// watchdog on total cycles
	always @(posedge clk) begin
		cycles = cycles + 1;
		if ((cycle_limit > 0) && (cycles >= cycle_limit)) begin
			$display("timeout: the run went past %0d clock cycles", cycle_limit);
			$display(">>> FAIL");
			$fatal(1, "simulation timed out");
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic is_branch_op(input alu_op_t op);
		return (op == OP_BEQ) || (op == OP_BLT) || (op == OP_BGE);
	endfunction

	function automatic int sat_step(input int v, input int max_v, input logic up);
		if (up)
			return (v < max_v) ? v + 1 : v;
		return (v > 0) ? v - 1 : v;
	endfunction

	// xor of consecutive width-bit chunks, last chunk cut at len
	function automatic logic [7:0] fold_chunks(input logic [T2_HIST-1:0] h, input int len,
			input int width);
		logic [31:0] acc;
		logic [31:0] chunk;
		int take;
		acc = '0;
		for (int c = 0; c < len; c += width) begin
			take = ((len - c) < width) ? (len - c) : width;
			chunk = (32'(h) >> c) & ((32'd1 << take) - 32'd1);
			acc = acc ^ chunk;
		end
		return acc[7:0];
	endfunction

	task automatic add_entry(input string name, input alu_op_t op, input pc_t p, input pc_t i,
			input logic t);
		stim_t s;
		s = '0;
		s.op = op;
		s.pc = p;
		s.imm = i;
		s.taken = t;
		tbl.push_back(s);
		names.push_back(name);
	endtask

	// predict entry k from model state, then apply its resolve
	task automatic model_apply(input int k);
		stim_t s;
		logic is_br;
		logic ctr_taken;
		logic [7:0] f;
		int bidx;
		int len;
		int prov;
		int idx [2];
		logic [TAG_W-1:0] tag [2];
		logic hit [2];
		s = tbl[k];
		is_br = is_branch_op(s.op);
		bidx = int'(s.pc[2 +: BASE_IDX_W]);
		for (int t = 0; t < 2; t++) begin
			len = (t == 0) ? T1_HIST : T2_HIST;
			f = fold_chunks(m_hist, len, TAG_IDX_W);
			idx[t] = int'(s.pc[2 +: TAG_IDX_W] ^ f[TAG_IDX_W-1:0]);
			f = fold_chunks(m_hist, len, TAG_W);
			tag[t] = s.pc[2 + TAG_IDX_W +: TAG_W] ^ f[TAG_W-1:0];
			hit[t] = m_valid[t][idx[t]] && (m_tag[t][idx[t]] == tag[t]);
		end
		// longest hitting history provides
		if (hit[1])
			prov = 2;
		else if (hit[0])
			prov = 1;
		else
			prov = 0;
		if (prov == 0)
			ctr_taken = m_base[bidx] >= 2'd2;
		else
			ctr_taken = m_ctr[prov-1][idx[prov-1]] >= CTR3_TAKEN_MIN;
		s.exp_taken = is_br && ctr_taken;
		s.exp_next_pc = s.exp_taken ? (s.pc + s.imm) : s.pc;
		tbl[k] = s;
		if (is_br) begin
			if (prov == 0)
				m_base[bidx] = ctr2_t'(sat_step(int'(m_base[bidx]), 3, s.taken));
			else
				m_ctr[prov-1][idx[prov-1]] =
					ctr3_t'(sat_step(int'(m_ctr[prov-1][idx[prov-1]]), 7, s.taken));
			// wrong guess from a shorter table claims one entry a table up
			if ((s.exp_taken != s.taken) && (prov < 2)) begin
				m_valid[prov][idx[prov]] = 1'b1;
				m_tag[prov][idx[prov]] = tag[prov];
				m_ctr[prov][idx[prov]] = s.taken ? ALLOC_TAKEN : ALLOC_NOT_TAKEN;
			end
			m_hist = {m_hist[T2_HIST-2:0], s.taken};
		end
	endtask

	task automatic check_taken(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %0b, actual %0b", name, exp, act);
			$display(">>> FAIL");
			$fatal(1, "direction mismatch");
		end
	endtask

	task automatic check_pc(input string name, input pc_t exp, input pc_t act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %08h, actual %08h", name, exp, act);
			$display(">>> FAIL");
			$fatal(1, "next address mismatch");
		end
	endtask

	task automatic build_table();
		logic [31:0] r;
		alu_op_t op;
		// fresh state, then t1 allocation with history still zero
		add_entry("reset_first", OP_BEQ, 32'h0000_0100, 32'h0000_0040, 1'b0);
		add_entry("non_branch", 6'h00, 32'h0000_0104, 32'h0000_0040, 1'b0);
		add_entry("alloc_t1", OP_BEQ, 32'h0000_0100, 32'h0000_0040, 1'b0);
		add_entry("reset_first", OP_BLT, 32'h0000_02c4, 32'hffff_fff8, 1'b0);
		add_entry("reset_first", OP_BGE, 32'h0000_051c, 32'h0000_0100, 1'b0);
		add_entry("non_branch", 6'h3f, 32'h0000_0600, 32'h0000_0004, 1'b1);
		add_entry("non_branch", 6'h0a, 32'h0000_02c4, 32'h0000_0080, 1'b0);
		// run up to saturation, one flip, then back
		for (int i = 0; i < 20; i++)
			add_entry("saturate", OP_BGE, 32'h0000_03f0, 32'h0000_0020, 1'b1);
		add_entry("saturate", OP_BGE, 32'h0000_03f0, 32'h0000_0020, 1'b0);
		add_entry("saturate", OP_BGE, 32'h0000_03f0, 32'h0000_0020, 1'b1);
		add_entry("saturate", OP_BGE, 32'h0000_03f0, 32'h0000_0020, 1'b1);
		add_entry("non_branch", 6'h21, 32'h0000_03f0, 32'h0000_0020, 1'b1);
		// t/nt alternation, the last four must already be right
		for (int i = 0; i < 40; i++) begin
			if (i == 36)
				learn_first = tbl.size();
			add_entry("alternate", OP_BEQ, 32'h0000_0480, 32'h0000_0010, (i % 2) == 0);
		end
		for (int i = 0; i < N_RAND; i++) begin
			r = lcg_next();
			case (r[18:16] % 3'd5)
				3'd0: op = OP_BEQ;
				3'd1: op = OP_BLT;
				3'd2: op = OP_BGE;
				default: op = alu_op_t'(r[29:24]);
			endcase
			// small word-aligned pc pool so entries alias and hit
			r = lcg_next();
			add_entry("random", op, r & 32'h0000_03fc, {{24{r[31]}}, r[29:24], 2'b00}, r[20]);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		alu_op = OP_ALU;
		pc = '0;
		imm = '0;
		resolve = 1'b0;
		taken = 1'b0;
		cycles = 0;
		cycle_limit = 0;
		learn_first = 0;
		lcg_state = 32'd53;
		m_hist = '0;
		for (int i = 0; i < 2 ** BASE_IDX_W; i++)
			m_base[i] = BASE_INIT;
		for (int t = 0; t < 2; t++) begin
			for (int i = 0; i < T_DEPTH; i++) begin
				m_valid[t][i] = 1'b0;
				m_tag[t][i] = '0;
				m_ctr[t][i] = '0;
			end
		end
		build_table();
		for (int k = 0; k < tbl.size(); k++)
			model_apply(k);
		// branch takes two cycles, anything else one
		cycle_limit = 2 * tbl.size() + RST_CYCLES + 50;

		repeat (RST_CYCLES) @(negedge clk);
		rst_n = 1'b1;

		for (int k = 0; k < tbl.size(); k++) begin
			@(negedge clk);
			alu_op = tbl[k].op;
			pc = tbl[k].pc;
			imm = tbl[k].imm;
			resolve = 1'b0;
			taken = 1'b0;
			// mid low phase, inputs settled
			#1;
			check_taken($sformatf("%s[%0d] direction", names[k], k), tbl[k].exp_taken,
				pred_taken);
			check_pc($sformatf("%s[%0d] next_pc", names[k], k), tbl[k].exp_next_pc, next_pc);
			if ((k >= learn_first) && (names[k] == "alternate"))
				check_taken($sformatf("%s[%0d] learned", names[k], k), tbl[k].taken,
					pred_taken);
			if (is_branch_op(tbl[k].op)) begin
				@(negedge clk);
				alu_op = OP_ALU;
				resolve = 1'b1;
				taken = tbl[k].taken;
			end
		end

		@(negedge clk);
		alu_op = OP_ALU;
		resolve = 1'b0;
		taken = 1'b0;
		repeat (2) @(negedge clk);
		$display(">>> PASS");
		$finish;
	end

endmodule

// File: test/bp_checker.sv
`timescale 1ns/1ps

module bp_checker (
	input logic clk,
	input logic rst_n,
	input bp_pkg::alu_op_t i_alu_op,
	input bp_pkg::pc_t i_pc,
	input bp_pkg::pc_t i_imm,
	input logic i_pred_taken,
	input bp_pkg::pc_t i_next_pc
);

	import bp_pkg::*;

	logic is_branch;

	// same three conditional codes as decode
	assign is_branch = (i_alu_op == OP_BEQ) || (i_alu_op == OP_BLT) ||
		(i_alu_op == OP_BGE);

	// non-branch falls through to pc
	a_non_branch: assert property (@(posedge clk) disable iff (!rst_n)
		!is_branch |-> (!i_pred_taken && (i_next_pc == i_pc)))
		else $error("non-branch opcode gave a taken prediction or a redirect");

	// taken means pc plus immediate
	a_taken_target: assert property (@(posedge clk) disable iff (!rst_n)
		i_pred_taken |-> (i_next_pc == i_pc + i_imm))
		else $error("taken prediction with a wrong target address");

	// no x or z on the prediction outputs
	a_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown({i_pred_taken, i_next_pc}))
		else $error("prediction outputs unknown after reset");

endmodule

bind bp_top bp_checker u_checker (
	.clk(clk),
	.rst_n(rst_n),
	.i_alu_op(i_alu_op),
	.i_pc(i_pc),
	.i_imm(i_imm),
	.i_pred_taken(o_pred_taken),
	.i_next_pc(o_next_pc)
);

// File: hw/bp_top.sv
`timescale 1ns/1ps

module bp_top #(
	parameter int BASE_IDX_W = 6,
	parameter int TAG_IDX_W = 5,
	parameter int T1_HIST = 8,
	parameter int T2_HIST = 16
) (
	input logic clk,
	input logic rst_n,
	input bp_pkg::alu_op_t i_alu_op,
	input bp_pkg::pc_t i_pc,
	input bp_pkg::pc_t i_imm,
	input logic i_resolve,
	input logic i_taken,
	output logic o_pred_taken,
	output bp_pkg::pc_t o_next_pc
);

	import bp_pkg::*;

	// lookup side
	logic [BASE_IDX_W-1:0] base_idx;
	logic [TAG_IDX_W-1:0] t1_idx;
	logic [TAG_IDX_W-1:0] t2_idx;
	logic [TAG_W-1:0] t1_tag;
	logic [TAG_W-1:0] t2_tag;
	ctr2_t base_ctr;
	tag_lookup_t t1_lookup;
	tag_lookup_t t2_lookup;
	logic is_branch;
	provider_e provider;

	// update side
	logic base_wr_en;
	logic [BASE_IDX_W-1:0] base_wr_idx;
	ctr2_t base_wr_ctr;
	logic t1_wr_en;
	logic [TAG_IDX_W-1:0] t1_wr_idx;
	tage_entry_t t1_wr_entry;
	logic t2_wr_en;
	logic [TAG_IDX_W-1:0] t2_wr_idx;
	tage_entry_t t2_wr_entry;

	// bimodal index skips the byte offset
	assign base_idx = i_pc[2 +: BASE_IDX_W];

	branch_history #(
		.TAG_IDX_W(TAG_IDX_W),
		.T1_HIST(T1_HIST),
		.T2_HIST(T2_HIST)
	) u_hist (
		.clk(clk),
		.rst_n(rst_n),
		.i_resolve(i_resolve),
		.i_taken(i_taken),
		.i_pc(i_pc),
		.o_t1_idx(t1_idx),
		.o_t1_tag(t1_tag),
		.o_t2_idx(t2_idx),
		.o_t2_tag(t2_tag)
	);

	base_table #(.BASE_IDX_W(BASE_IDX_W)) u_base (
		.clk(clk),
		.rst_n(rst_n),
		.i_rd_idx(base_idx),
		.o_ctr(base_ctr),
		.i_wr_en(base_wr_en),
		.i_wr_idx(base_wr_idx),
		.i_wr_ctr(base_wr_ctr)
	);

	tagged_table #(.TAG_IDX_W(TAG_IDX_W)) u_t1 (
		.clk(clk),
		.rst_n(rst_n),
		.i_rd_idx(t1_idx),
		.i_rd_tag(t1_tag),
		.o_lookup(t1_lookup),
		.i_wr_en(t1_wr_en),
		.i_wr_idx(t1_wr_idx),
		.i_wr_entry(t1_wr_entry)
	);

	tagged_table #(.TAG_IDX_W(TAG_IDX_W)) u_t2 (
		.clk(clk),
		.rst_n(rst_n),
		.i_rd_idx(t2_idx),
		.i_rd_tag(t2_tag),
		.o_lookup(t2_lookup),
		.i_wr_en(t2_wr_en),
		.i_wr_idx(t2_wr_idx),
		.i_wr_entry(t2_wr_entry)
	);

	predict_select u_sel (
		.i_alu_op(i_alu_op),
		.i_pc(i_pc),
		.i_imm(i_imm),
		.i_base_ctr(base_ctr),
		.i_t1(t1_lookup),
		.i_t2(t2_lookup),
		.o_is_branch(is_branch),
		.o_provider(provider),
		.o_pred_taken(o_pred_taken),
		.o_next_pc(o_next_pc)
	);

	update_ctrl #(
		.BASE_IDX_W(BASE_IDX_W),
		.TAG_IDX_W(TAG_IDX_W)
	) u_upd (
		.clk(clk),
		.rst_n(rst_n),
		.i_is_branch(is_branch),
		.i_provider(provider),
		.i_pred_taken(o_pred_taken),
		.i_base_idx(base_idx),
		.i_t1_idx(t1_idx),
		.i_t1_tag(t1_tag),
		.i_t2_idx(t2_idx),
		.i_t2_tag(t2_tag),
		.i_base_ctr(base_ctr),
		.i_t1(t1_lookup),
		.i_t2(t2_lookup),
		.i_resolve(i_resolve),
		.i_taken(i_taken),
		.o_base_wr_en(base_wr_en),
		.o_base_wr_idx(base_wr_idx),
		.o_base_wr_ctr(base_wr_ctr),
		.o_t1_wr_en(t1_wr_en),
		.o_t1_wr_idx(t1_wr_idx),
		.o_t1_wr_entry(t1_wr_entry),
		.o_t2_wr_en(t2_wr_en),
		.o_t2_wr_idx(t2_wr_idx),
		.o_t2_wr_entry(t2_wr_entry)
	);

endmodule

// File: tage/update_ctrl.sv
`timescale 1ns/1ps

module update_ctrl #(
	parameter int BASE_IDX_W = 6,
	parameter int TAG_IDX_W = 5
) (
	input logic clk,
	input logic rst_n,
	input logic i_is_branch,
	input bp_pkg::provider_e i_provider,
	input logic i_pred_taken,
	input logic [BASE_IDX_W-1:0] i_base_idx,
	input logic [TAG_IDX_W-1:0] i_t1_idx,
	input logic [bp_pkg::TAG_W-1:0] i_t1_tag,
	input logic [TAG_IDX_W-1:0] i_t2_idx,
	input logic [bp_pkg::TAG_W-1:0] i_t2_tag,
	input bp_pkg::ctr2_t i_base_ctr,
	input bp_pkg::tag_lookup_t i_t1,
	input bp_pkg::tag_lookup_t i_t2,
	input logic i_resolve,
	input logic i_taken,
	output logic o_base_wr_en,
	output logic [BASE_IDX_W-1:0] o_base_wr_idx,
	output bp_pkg::ctr2_t o_base_wr_ctr,
	output logic o_t1_wr_en,
	output logic [TAG_IDX_W-1:0] o_t1_wr_idx,
	output bp_pkg::tage_entry_t o_t1_wr_entry,
	output logic o_t2_wr_en,
	output logic [TAG_IDX_W-1:0] o_t2_wr_idx,
	output bp_pkg::tage_entry_t o_t2_wr_entry
);

	import bp_pkg::*;

	branch_rec_t rec_d;
	branch_rec_t rec_q;
	logic upd;
	logic mispred;
	ctr3_t alloc_ctr;

	// snapshot of the branch being predicted now
	always_comb begin
		rec_d.valid = 1'b1;
		rec_d.base_idx = MAX_IDX_W'(i_base_idx);
		rec_d.t1_idx = MAX_IDX_W'(i_t1_idx);
		rec_d.t1_tag = i_t1_tag;
		rec_d.t2_idx = MAX_IDX_W'(i_t2_idx);
		rec_d.t2_tag = i_t2_tag;
		rec_d.provider = i_provider;
		rec_d.pred_taken = i_pred_taken;
		case (i_provider)
			PROV_T2: rec_d.prov_ctr = i_t2.ctr;
			PROV_T1: rec_d.prov_ctr = i_t1.ctr;
			default: rec_d.prov_ctr = {1'b0, i_base_ctr};
		endcase
	end

	// a new branch overrides the clear from a resolve in the same edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rec_q <= '0;
		else if (i_is_branch)
			rec_q <= rec_d;
		else if (i_resolve)
			rec_q.valid <= 1'b0;
	end

	assign upd = i_resolve && rec_q.valid;
	assign mispred = rec_q.pred_taken != i_taken;
	assign alloc_ctr = i_taken ? ALLOC_TAKEN : ALLOC_NOT_TAKEN;

	// provider step, plus allocation one table up on a miss
	always_comb begin
		o_base_wr_en = upd && (rec_q.provider == PROV_BASE);
		o_base_wr_idx = rec_q.base_idx[BASE_IDX_W-1:0];
		o_base_wr_ctr = ctr2_next(rec_q.prov_ctr[1:0], i_taken);

		o_t1_wr_en = upd && ((rec_q.provider == PROV_T1) ||
			((rec_q.provider == PROV_BASE) && mispred));
		o_t1_wr_idx = rec_q.t1_idx[TAG_IDX_W-1:0];
		o_t1_wr_entry.valid = 1'b1;
		o_t1_wr_entry.tag = rec_q.t1_tag;
		if (rec_q.provider == PROV_T1)
			o_t1_wr_entry.ctr = ctr3_next(rec_q.prov_ctr, i_taken);
		else
			o_t1_wr_entry.ctr = alloc_ctr;

		// t2 is the longest table, nothing above it to allocate into
		o_t2_wr_en = upd && ((rec_q.provider == PROV_T2) ||
			((rec_q.provider == PROV_T1) && mispred));
		o_t2_wr_idx = rec_q.t2_idx[TAG_IDX_W-1:0];
		o_t2_wr_entry.valid = 1'b1;
		o_t2_wr_entry.tag = rec_q.t2_tag;
		if (rec_q.provider == PROV_T2)
			o_t2_wr_entry.ctr = ctr3_next(rec_q.prov_ctr, i_taken);
		else
			o_t2_wr_entry.ctr = alloc_ctr;
	end

endmodule

// File: tage/predict_select.sv
`timescale 1ns/1ps

module predict_select (
	input bp_pkg::alu_op_t i_alu_op,
	input bp_pkg::pc_t i_pc,
	input bp_pkg::pc_t i_imm,
	input bp_pkg::ctr2_t i_base_ctr,
	input bp_pkg::tag_lookup_t i_t1,
	input bp_pkg::tag_lookup_t i_t2,
	output logic o_is_branch,
	output bp_pkg::provider_e o_provider,
	output logic o_pred_taken,
	output bp_pkg::pc_t o_next_pc
);

	import bp_pkg::*;

	logic prov_taken;

	// conditional branches only
	assign o_is_branch = (i_alu_op == OP_BEQ) || (i_alu_op == OP_BLT) ||
		(i_alu_op == OP_BGE);

	// longest history that hits wins
	always_comb begin
		if (i_t2.hit) begin
			o_provider = PROV_T2;
			prov_taken = i_t2.ctr >= CTR3_TAKEN_MIN;
		end else if (i_t1.hit) begin
			o_provider = PROV_T1;
			prov_taken = i_t1.ctr >= CTR3_TAKEN_MIN;
		end else begin
			o_provider = PROV_BASE;
			// upper half of the 2-bit range
			prov_taken = i_base_ctr[1];
		end
	end

	// anything that is not a branch falls through
	assign o_pred_taken = o_is_branch && prov_taken;

	assign o_next_pc = o_pred_taken ? (i_pc + i_imm) : i_pc;

endmodule

// File: tage/tagged_table.sv
`timescale 1ns/1ps

module tagged_table #(
	parameter int TAG_IDX_W = 5
) (
	input logic clk,
	input logic rst_n,
	input logic [TAG_IDX_W-1:0] i_rd_idx,
	input logic [bp_pkg::TAG_W-1:0] i_rd_tag,
	output bp_pkg::tag_lookup_t o_lookup,
	input logic i_wr_en,
	input logic [TAG_IDX_W-1:0] i_wr_idx,
	input bp_pkg::tage_entry_t i_wr_entry
);

	import bp_pkg::*;

	localparam int DEPTH = 2 ** TAG_IDX_W;

	// valid bits kept apart from the entry payload
	logic [DEPTH-1:0] valid_q;
	logic [TAG_W-1:0] tag_q [DEPTH];
	ctr3_t ctr_q [DEPTH];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			valid_q <= '0;
		else if (i_wr_en)
			valid_q[i_wr_idx] <= i_wr_entry.valid;
	end

	// whole entry rewritten, both for a counter step and an allocation
	always_ff @(posedge clk) begin
		if (i_wr_en) begin
			tag_q[i_wr_idx] <= i_wr_entry.tag;
			ctr_q[i_wr_idx] <= i_wr_entry.ctr;
		end
	end

	// hit needs a live entry and matching tag
	always_comb begin
		o_lookup.hit = valid_q[i_rd_idx] && (tag_q[i_rd_idx] == i_rd_tag);
		o_lookup.ctr = ctr_q[i_rd_idx];
	end

endmodule

// File: tage/base_table.sv
`timescale 1ns/1ps

module base_table #(
	parameter int BASE_IDX_W = 6
) (
	input logic clk,
	input logic rst_n,
	input logic [BASE_IDX_W-1:0] i_rd_idx,
	output bp_pkg::ctr2_t o_ctr,
	input logic i_wr_en,
	input logic [BASE_IDX_W-1:0] i_wr_idx,
	input bp_pkg::ctr2_t i_wr_ctr
);

	import bp_pkg::*;

	localparam int DEPTH = 2 ** BASE_IDX_W;

	ctr2_t ctr_q [DEPTH];

	// every counter starts weakly taken
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++)
				ctr_q[i] <= BASE_INIT;
		end else if (i_wr_en) begin
			ctr_q[i_wr_idx] <= i_wr_ctr;
		end
	end

	// read sees the old value during a write cycle
	assign o_ctr = ctr_q[i_rd_idx];

endmodule

// File: hw/branch_history.sv
`timescale 1ns/1ps

module branch_history #(
	parameter int TAG_IDX_W = 5,
	parameter int T1_HIST = 8,
	parameter int T2_HIST = 16
) (
	input logic clk,
	input logic rst_n,
	input logic i_resolve,
	input logic i_taken,
	input bp_pkg::pc_t i_pc,
	output logic [TAG_IDX_W-1:0] o_t1_idx,
	output logic [bp_pkg::TAG_W-1:0] o_t1_tag,
	output logic [TAG_IDX_W-1:0] o_t2_idx,
	output logic [bp_pkg::TAG_W-1:0] o_t2_tag
);

	import bp_pkg::*;

	// newest outcome at bit 0
	logic [T2_HIST-1:0] hist_q;
	logic [MAX_HIST-1:0] hist_ext;

	// folds at full bound width, sliced below
	logic [MAX_IDX_W-1:0] t1_idx_fold;
	logic [MAX_IDX_W-1:0] t1_tag_fold;
	logic [MAX_IDX_W-1:0] t2_idx_fold;
	logic [MAX_IDX_W-1:0] t2_tag_fold;

	// one shift per resolved branch
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			hist_q <= '0;
		else if (i_resolve)
			hist_q <= {hist_q[T2_HIST-2:0], i_taken};
	end

	assign hist_ext = MAX_HIST'(hist_q);

	// tables differ only in how much history gets folded in
	assign t1_idx_fold = fold_hist(hist_ext, T1_HIST, TAG_IDX_W);
	assign t1_tag_fold = fold_hist(hist_ext, T1_HIST, TAG_W);
	assign t2_idx_fold = fold_hist(hist_ext, T2_HIST, TAG_IDX_W);
	assign t2_tag_fold = fold_hist(hist_ext, T2_HIST, TAG_W);

	// index from the pc bits just above the byte offset
	assign o_t1_idx = i_pc[2 +: TAG_IDX_W] ^ t1_idx_fold[TAG_IDX_W-1:0];
	assign o_t2_idx = i_pc[2 +: TAG_IDX_W] ^ t2_idx_fold[TAG_IDX_W-1:0];

	// tag from the next pc bits up, so it adds information the index lacks
	assign o_t1_tag = i_pc[2 + TAG_IDX_W +: TAG_W] ^ t1_tag_fold[TAG_W-1:0];
	assign o_t2_tag = i_pc[2 + TAG_IDX_W +: TAG_W] ^ t2_tag_fold[TAG_W-1:0];

endmodule

// File: common/bp_pkg.sv
package bp_pkg;

	// conditional branch opcodes from decode
	typedef logic [5:0] alu_op_t;

	localparam alu_op_t OP_BEQ = 6'b001011;
	localparam alu_op_t OP_BLT = 6'b001100;
	localparam alu_op_t OP_BGE = 6'b001101;

	localparam int PC_W = 32;
	typedef logic [PC_W-1:0] pc_t;

	// upper bounds for struct fields, module parameters stay below these
	localparam int MAX_IDX_W = 8;
	localparam int TAG_W = 4;
	localparam int MAX_HIST = 32;

	// bimodal counter, starts weakly taken
	typedef logic [1:0] ctr2_t;
	localparam ctr2_t BASE_INIT = 2'd2;

	// tagged counter
	typedef logic [2:0] ctr3_t;
	localparam ctr3_t CTR3_TAKEN_MIN = 3'd4;
	localparam ctr3_t ALLOC_TAKEN = 3'd4;
	localparam ctr3_t ALLOC_NOT_TAKEN = 3'd3;

	typedef enum logic [1:0] {
		PROV_BASE = 2'd0,
		PROV_T1 = 2'd1,
		PROV_T2 = 2'd2
	} provider_e;

	typedef struct packed {
		logic valid;
		logic [TAG_W-1:0] tag;
		ctr3_t ctr;
	} tage_entry_t;

	typedef struct packed {
		logic hit;
		ctr3_t ctr;
	} tag_lookup_t;

	// one predicted branch, held until its resolve
	typedef struct packed {
		logic valid;
		logic [MAX_IDX_W-1:0] base_idx;
		logic [MAX_IDX_W-1:0] t1_idx;
		logic [TAG_W-1:0] t1_tag;
		logic [MAX_IDX_W-1:0] t2_idx;
		logic [TAG_W-1:0] t2_tag;
		provider_e provider;
		logic pred_taken;
		// base counter sits in the low two bits
		ctr3_t prov_ctr;
	} branch_rec_t;

	function automatic ctr2_t ctr2_next(input ctr2_t c, input logic up);
		if (up && (c != 2'd3))
			return c + 2'd1;
		else if (!up && (c != 2'd0))
			return c - 2'd1;
		return c;
	endfunction

	function automatic ctr3_t ctr3_next(input ctr3_t c, input logic up);
		if (up && (c != 3'd7))
			return c + 3'd1;
		else if (!up && (c != 3'd0))
			return c - 3'd1;
		return c;
	endfunction

	// xor the lowest len history bits down to width bits, chunk by chunk
	function automatic logic [MAX_IDX_W-1:0] fold_hist(input logic [MAX_HIST-1:0] hist,
			input int len, input int width);
		logic [MAX_IDX_W-1:0] res;
		res = '0;
		for (int i = 0; i < MAX_HIST; i++) begin
			if (i < len)
				res[i % width] = res[i % width] ^ hist[i];
		end
		return res;
	endfunction

endpackage
